// File: hdl/lv_core_cfg.svh
//========================================
// lv core configuration
// register file geometry and scanner pacing
//========================================
`ifndef LV_CORE_CFG_SVH
`define LV_CORE_CFG_SVH

//========================================
// register file
//========================================
`define LV_REG_NUM      8   // last address is the status register
`define LV_REG_AW       3
`define LV_REG_DW       8
`define LV_REG_CRC_W    4

//========================================
// watchdog scanner
//========================================
// idle cycles between two scan reads
`define LV_SCAN_GAP     16

`endif

// File: hdl/lv_pkg.sv
//========================================
// lv_pkg
// shared types, state encodings and the
// register CRC4 function
//========================================
`default_nettype none

`include "lv_core_cfg.svh"

package lv_pkg;

    typedef logic [`LV_REG_AW-1:0]    reg_addr_t;
    typedef logic [`LV_REG_DW-1:0]    reg_data_t;
    typedef logic [`LV_REG_CRC_W-1:0] reg_crc_t;

    typedef enum logic {
        LV_OP_RD = 1'b0,
        LV_OP_WR = 1'b1
    } lv_op_e;

    // arbiter
    typedef enum logic [1:0] {
        RAC_IDLE,
        RAC_ACCESS,
        RAC_ACK,
        RAC_RELEASE
    } rac_st_e;

    // watchdog scanner
    typedef enum logic [1:0] {
        SCAN_GAP,
        SCAN_REQ,
        SCAN_WAIT,
        SCAN_RELEASE
    } scan_st_e;

    localparam reg_crc_t LV_CRC_POLY = 4'h3; // x^4+x+1

    // zero seed, data msb first
    function automatic reg_crc_t lv_crc4(input reg_data_t data);
        reg_crc_t crc;
        logic     fb;
        crc = '0;
        for (int i = `LV_REG_DW - 1; i >= 0; i--) begin
            fb  = crc[`LV_REG_CRC_W-1] ^ data[i];
            crc = {crc[`LV_REG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ LV_CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

// File: hdl/lv_wdg_scan.sv
//========================================
// lv_wdg_scan
// watchdog scanner, reads each config
// register in turn and checks its CRC
//========================================
`default_nettype none

`include "lv_core_cfg.svh"

module lv_wdg_scan import lv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_scan_en,

    output logic        o_scan_req,
    output reg_addr_t   o_scan_addr,
    input  logic        i_scan_ack,
    input  reg_data_t   i_scan_rdata,
    input  reg_crc_t    i_scan_rcrc,

    output logic        o_crc_mismatch
);

localparam int        GAP_W     = $clog2(`LV_SCAN_GAP + 1);
localparam reg_addr_t LAST_ADDR = reg_addr_t'(`LV_REG_NUM - 2); // status reg skipped

scan_st_e           state;
logic [GAP_W-1:0]   gap_cnt;
logic               gap_done;

assign gap_done = (gap_cnt == GAP_W'(`LV_SCAN_GAP - 1));

//========================================
// scan FSM
//========================================
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        state          <= SCAN_GAP;
        gap_cnt        <= '0;
        o_scan_req     <= 1'b0;
        o_scan_addr    <= '0;
        o_crc_mismatch <= 1'b0;
    end else begin
        o_crc_mismatch <= 1'b0;
        case (state)
            SCAN_GAP: begin
                if (!i_scan_en) begin
                    gap_cnt <= '0;       // parked
                end else if (gap_done) begin
                    gap_cnt <= '0;
                    state   <= SCAN_REQ;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
            SCAN_REQ: begin
                o_scan_req <= 1'b1;
                state      <= SCAN_WAIT;
            end
            SCAN_WAIT: begin
                if (i_scan_ack) begin
                    o_scan_req     <= 1'b0;
                    o_crc_mismatch <= (lv_crc4(i_scan_rdata) != i_scan_rcrc);
                    state          <= SCAN_RELEASE;
                end
            end
            default: begin
                // wait for ack low before moving on
                if (!i_scan_ack) begin
                    o_scan_addr <= (o_scan_addr == LAST_ADDR) ? '0 : o_scan_addr + 1'b1;
                    state       <= SCAN_GAP;
                end
            end
        endcase
    end
end

//========================================
// assertions
//========================================
a_addr_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_scan_addr < reg_addr_t'(`LV_REG_NUM - 1))
    else $error("scanner address reached the status register");

endmodule

`default_nettype wire

// File: hdl/lv_reg_access_ctrl.sv
//========================================
// lv_reg_access_ctrl
// round-robin arbiter between host port and
// watchdog scanner, one register access per
// four-phase handshake
//========================================
`default_nettype none

module lv_reg_access_ctrl import lv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_host_req,
    input  lv_op_e      i_host_op,
    input  reg_addr_t   i_host_addr,
    input  reg_data_t   i_host_wdata,
    input  reg_crc_t    i_host_wcrc,
    output logic        o_host_ack,
    output reg_data_t   o_host_rdata,
    output reg_crc_t    o_host_rcrc,

    input  logic        i_scan_req,
    input  reg_addr_t   i_scan_addr,
    output logic        o_scan_ack,
    output reg_data_t   o_scan_rdata,
    output reg_crc_t    o_scan_rcrc,

    output logic        o_reg_ren,
    output logic        o_reg_wen,
    output reg_addr_t   o_reg_addr,
    output reg_data_t   o_reg_wdata,
    output reg_crc_t    o_reg_wcrc,
    input  logic        i_reg_rack,
    input  logic        i_reg_wack,
    input  reg_data_t   i_reg_rdata,
    input  reg_crc_t    i_reg_rcrc
);

rac_st_e    state;
logic       owner_scan;     // 1: scanner holds the current grant
logic       last_scan;      // round-robin history
logic       ack_q;
logic       grant_vld;
logic       grant_scan;
logic       owner_req;

assign grant_vld  = i_host_req | i_scan_req;
assign grant_scan = i_scan_req & (~i_host_req | ~last_scan);
assign owner_req  = owner_scan ? i_scan_req : i_host_req;

assign o_host_ack = ack_q & ~owner_scan;
assign o_scan_ack = ack_q & owner_scan;

//========================================
// handshake FSM
//========================================
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        state      <= RAC_IDLE;
        owner_scan <= 1'b0;
        last_scan  <= 1'b0;
        ack_q      <= 1'b0;
        o_reg_ren  <= 1'b0;
        o_reg_wen  <= 1'b0;
    end else begin
        o_reg_ren <= 1'b0; // single cycle strobes
        o_reg_wen <= 1'b0;
        case (state)
            RAC_IDLE: begin
                if (grant_vld) begin
                    state      <= RAC_ACCESS;
                    owner_scan <= grant_scan;
                    last_scan  <= grant_scan;
                    if (!grant_scan && i_host_op == LV_OP_WR) begin
                        o_reg_wen <= 1'b1;
                    end else begin
                        o_reg_ren <= 1'b1;
                    end
                end
            end
            RAC_ACCESS: begin
                if (i_reg_rack || i_reg_wack) begin
                    ack_q <= 1'b1;
                    state <= RAC_ACK;
                end
            end
            RAC_ACK: begin
                if (!owner_req) begin
                    ack_q <= 1'b0;
                    state <= RAC_RELEASE;
                end
            end
            default: state <= RAC_IDLE; // release, one spare cycle
        endcase
    end
end

// request fields and response data
always_ff @(posedge i_clk) begin
    if (state == RAC_IDLE && grant_vld) begin
        o_reg_addr  <= grant_scan ? i_scan_addr : i_host_addr;
        o_reg_wdata <= i_host_wdata;
        o_reg_wcrc  <= i_host_wcrc;
    end
    if (state == RAC_ACCESS && i_reg_rack) begin
        if (owner_scan) begin
            o_scan_rdata <= i_reg_rdata;
            o_scan_rcrc  <= i_reg_rcrc;
        end else begin
            o_host_rdata <= i_reg_rdata;
            o_host_rcrc  <= i_reg_rcrc;
        end
    end
end

//========================================
// assertions
//========================================
a_ren_wen_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_reg_ren && o_reg_wen))
    else $error("reg_ren and reg_wen high together");

a_host_ack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_host_ack) |-> i_host_req)
    else $error("host ack raised without host req");

a_scan_ack_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_scan_ack) |-> i_scan_req)
    else $error("scan ack raised without scan req");

endmodule

`default_nettype wire

// File: hdl/lv_reg_slv.sv
//========================================
// lv_reg_slv
// register file, data and CRC per entry,
// last address holds the sticky CRC error
//========================================
`default_nettype none

`include "lv_core_cfg.svh"

module lv_reg_slv import lv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_reg_ren,
    input  logic        i_reg_wen,
    input  reg_addr_t   i_reg_addr,
    input  reg_data_t   i_reg_wdata,
    input  reg_crc_t    i_reg_wcrc,
    output logic        o_reg_rack,
    output logic        o_reg_wack,
    output reg_data_t   o_reg_rdata,
    output reg_crc_t    o_reg_rcrc,

    input  logic        i_crc_mismatch,
    output logic        o_crc_err
);

localparam reg_addr_t STAT_ADDR = reg_addr_t'(`LV_REG_NUM - 1);

reg_data_t  mem_data [`LV_REG_NUM-1];
reg_crc_t   mem_crc  [`LV_REG_NUM-1];
reg_data_t  stat_val;
logic       stat_sel;
logic       err_clr;

assign stat_sel = (i_reg_addr == STAT_ADDR);
assign stat_val = {{(`LV_REG_DW-1){1'b0}}, o_crc_err};
assign err_clr  = i_reg_wen & stat_sel & i_reg_wdata[0]; // write 1 to clear

//========================================
// storage
//========================================
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        for (int i = 0; i < `LV_REG_NUM - 1; i++) begin
            mem_data[i] <= '0;
            mem_crc[i]  <= '0;
        end
    end else if (i_reg_wen && !stat_sel) begin
        mem_data[i_reg_addr] <= i_reg_wdata;   // crc kept as supplied
        mem_crc[i_reg_addr]  <= i_reg_wcrc;
    end
end

// sticky error, set has priority
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        o_crc_err <= 1'b0;
    end else if (i_crc_mismatch) begin
        o_crc_err <= 1'b1;
    end else if (err_clr) begin
        o_crc_err <= 1'b0;
    end
end

//========================================
// response, one cycle after the strobe
//========================================
always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
        o_reg_rack <= 1'b0;
        o_reg_wack <= 1'b0;
    end else begin
        o_reg_rack <= i_reg_ren;
        o_reg_wack <= i_reg_wen;
    end
end

always_ff @(posedge i_clk) begin
    if (i_reg_ren) begin
        if (stat_sel) begin
            o_reg_rdata <= stat_val;
            o_reg_rcrc  <= lv_crc4(stat_val);
        end else begin
            o_reg_rdata <= mem_data[i_reg_addr];
            o_reg_rcrc  <= mem_crc[i_reg_addr];
        end
    end
end

//========================================
// assertions
//========================================
a_ren_rack: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_reg_ren |=> o_reg_rack)
    else $error("reg_rack missing one cycle after reg_ren");

endmodule

`default_nettype wire

// File: hdl/lv_core.sv
//========================================
// lv_core
// register subsystem top, host port and
// watchdog scanner sharing one register file
//========================================
`default_nettype none

module lv_core import lv_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,

    input  logic        i_host_req,
    input  lv_op_e      i_host_op,
    input  reg_addr_t   i_host_addr,
    input  reg_data_t   i_host_wdata,
    input  reg_crc_t    i_host_wcrc,
    output logic        o_host_ack,
    output reg_data_t   o_host_rdata,
    output reg_crc_t    o_host_rcrc,

    input  logic        i_scan_en,      // scanner run enable
    output logic        o_crc_err
);

// scanner <-> arbiter
logic       scan_req;
reg_addr_t  scan_addr;
logic       scan_ack;
reg_data_t  scan_rdata;
reg_crc_t   scan_rcrc;
logic       crc_mismatch;

// arbiter <-> register file
logic       reg_ren;
logic       reg_wen;
reg_addr_t  reg_addr;
reg_data_t  reg_wdata;
reg_crc_t   reg_wcrc;
logic       reg_rack;
logic       reg_wack;
reg_data_t  reg_rdata;
reg_crc_t   reg_rcrc;

lv_wdg_scan u_lv_wdg_scan (
    .i_clk              (i_clk          ),
    .i_rst_n            (i_rst_n        ),
    .i_scan_en          (i_scan_en      ),
    .o_scan_req         (scan_req       ),
    .o_scan_addr        (scan_addr      ),
    .i_scan_ack         (scan_ack       ),
    .i_scan_rdata       (scan_rdata     ),
    .i_scan_rcrc        (scan_rcrc      ),
    .o_crc_mismatch     (crc_mismatch   )
);

lv_reg_access_ctrl u_lv_reg_access_ctrl (
    .i_clk              (i_clk          ),
    .i_rst_n            (i_rst_n        ),
    .i_host_req         (i_host_req     ),
    .i_host_op          (i_host_op      ),
    .i_host_addr        (i_host_addr    ),
    .i_host_wdata       (i_host_wdata   ),
    .i_host_wcrc        (i_host_wcrc    ),
    .o_host_ack         (o_host_ack     ),
    .o_host_rdata       (o_host_rdata   ),
    .o_host_rcrc        (o_host_rcrc    ),
    .i_scan_req         (scan_req       ),
    .i_scan_addr        (scan_addr      ),
    .o_scan_ack         (scan_ack       ),
    .o_scan_rdata       (scan_rdata     ),
    .o_scan_rcrc        (scan_rcrc      ),
    .o_reg_ren          (reg_ren        ),
    .o_reg_wen          (reg_wen        ),
    .o_reg_addr         (reg_addr       ),
    .o_reg_wdata        (reg_wdata      ),
    .o_reg_wcrc         (reg_wcrc       ),
    .i_reg_rack         (reg_rack       ),
    .i_reg_wack         (reg_wack       ),
    .i_reg_rdata        (reg_rdata      ),
    .i_reg_rcrc         (reg_rcrc       )
);

lv_reg_slv u_lv_reg_slv (
    .i_clk              (i_clk          ),
    .i_rst_n            (i_rst_n        ),
    .i_reg_ren          (reg_ren        ),
    .i_reg_wen          (reg_wen        ),
    .i_reg_addr         (reg_addr       ),
    .i_reg_wdata        (reg_wdata      ),
    .i_reg_wcrc         (reg_wcrc       ),
    .o_reg_rack         (reg_rack       ),
    .o_reg_wack         (reg_wack       ),
    .o_reg_rdata        (reg_rdata      ),
    .o_reg_rcrc         (reg_rcrc       ),
    .i_crc_mismatch     (crc_mismatch   ),
    .o_crc_err          (o_crc_err      )
);

endmodule

`default_nettype wire

// File: sim/tb_lv_core.sv
//========================================
// tb_lv_core
// testbench for the register subsystem,
// host traffic against the watchdog scanner
//========================================
`default_nettype none

`include "lv_core_cfg.svh"

module tb_lv_core import lv_pkg::*; ();

localparam int        HOST_TMO  = 200;      // cycles per handshake phase
localparam int        ERR_TMO   = 1000;
localparam int        SCAN_TMO  = 64;       // cycles allowed per scan read
localparam reg_addr_t STAT_ADDR = reg_addr_t'(`LV_REG_NUM - 1);

logic       clk;
logic       rst_n;
logic       host_req;
lv_op_e     host_op;
reg_addr_t  host_addr;
reg_data_t  host_wdata;
reg_crc_t   host_wcrc;
logic       o_host_ack;
reg_data_t  o_host_rdata;
reg_crc_t   o_host_rcrc;
logic       scan_en;
logic       o_crc_err;

// model of the register file
reg_data_t  exp_data [`LV_REG_NUM];
reg_crc_t   exp_crc  [`LV_REG_NUM];
logic       exp_err;
logic       err_allowed;    // a bad CRC sits in the register file
reg_data_t  exp_stat;
reg_crc_t   exp_stat_crc;

lv_core dut0 (
    .i_clk          (clk            ),
    .i_rst_n        (rst_n          ),
    .i_host_req     (host_req       ),
    .i_host_op      (host_op        ),
    .i_host_addr    (host_addr      ),
    .i_host_wdata   (host_wdata     ),
    .i_host_wcrc    (host_wcrc      ),
    .o_host_ack     (o_host_ack     ),
    .o_host_rdata   (o_host_rdata   ),
    .o_host_rcrc    (o_host_rcrc    ),
    .i_scan_en      (scan_en        ),
    .o_crc_err      (o_crc_err      )
);

always #10 clk = ~clk;

// remainder of data * x^4 divided by x^4+x+1
function automatic reg_crc_t crc4_remainder(input reg_data_t d);
    logic [11:0] r;
    r = {d, 4'h0};
    for (int i = 11; i >= 4; i--) begin
        if (r[i]) begin
            r = r ^ (12'h013 << (i - 4));
        end
    end
    return r[3:0];
endfunction

assign exp_stat     = reg_data_t'(exp_err);
assign exp_stat_crc = crc4_remainder(exp_stat);

task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
endtask

//========================================
// host port, one four-phase access
//========================================
task automatic host_access(input lv_op_e op, input reg_addr_t addr,
                           input reg_data_t wdata, input reg_crc_t wcrc);
    int cyc;
    host_op    = op;
    host_addr  = addr;
    host_wdata = wdata;
    host_wcrc  = wcrc;
    host_req   = 1'b1;
    cyc        = 0;
    while (!o_host_ack && cyc < HOST_TMO) begin
        @(posedge clk);
        #2;
        cyc++;
    end
    if (!o_host_ack) begin
        abort_run("host ack did not rise within the timeout");
    end
    @(posedge clk);     // req held one cycle past ack
    #2;
    host_req = 1'b0;
    cyc      = 0;
    while (o_host_ack && cyc < HOST_TMO) begin
        @(posedge clk);
        #2;
        cyc++;
    end
    if (o_host_ack) begin
        abort_run("host ack did not fall after host req was released");
    end
    @(posedge clk);     // idle between accesses
    #2;
    if (op == LV_OP_WR && addr != STAT_ADDR) begin
        exp_data[addr] = wdata;
        exp_crc[addr]  = wcrc;
    end
endtask

task automatic wait_scan_reads(input int count);
    int   seen;
    int   cyc;
    logic prev;
    seen = 0;
    cyc  = 0;
    prev = dut0.scan_ack;
    while (seen < count && cyc < count * SCAN_TMO) begin
        @(posedge clk);
        #2;
        cyc++;
        if (dut0.scan_ack && !prev) begin
            seen++;
        end
        prev = dut0.scan_ack;
    end
    if (seen < count) begin
        abort_run("scanner made too few reads before the timeout");
    end
endtask

task automatic wait_crc_err();
    int cyc;
    cyc = 0;
    while (!o_crc_err && cyc < ERR_TMO) begin
        @(posedge clk);
        #2;
        cyc++;
    end
    if (!o_crc_err) begin
        abort_run("o_crc_err did not rise after a write with a bad CRC");
    end
endtask

//========================================
// checks
//========================================
a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_host_ack) |-> host_req)
    else abort_run("host ack rose while host req was low");

a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(o_host_ack) |-> !host_req)
    else abort_run("host ack fell while host req was still high");

a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_host_ack) && host_op == LV_OP_RD && host_addr != STAT_ADDR
    |-> o_host_rdata == exp_data[host_addr])
    else abort_run($sformatf("Fail: o_host_rdata addr %h got %h expected %h",
                             host_addr, o_host_rdata, exp_data[host_addr]));

a_rcrc: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_host_ack) && host_op == LV_OP_RD && host_addr != STAT_ADDR
    |-> o_host_rcrc == exp_crc[host_addr])
    else abort_run($sformatf("Fail: o_host_rcrc addr %h got %h expected %h",
                             host_addr, o_host_rcrc, exp_crc[host_addr]));

a_stat_data: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_host_ack) && host_op == LV_OP_RD && host_addr == STAT_ADDR
    |-> o_host_rdata == exp_stat)
    else abort_run($sformatf("Fail: o_host_rdata status got %h expected %h",
                             o_host_rdata, exp_stat));

a_stat_crc: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(o_host_ack) && host_op == LV_OP_RD && host_addr == STAT_ADDR
    |-> o_host_rcrc == exp_stat_crc)
    else abort_run($sformatf("Fail: o_host_rcrc status got %h expected %h",
                             o_host_rcrc, exp_stat_crc));

a_err_low: assert property (@(posedge clk) disable iff (!rst_n)
    !err_allowed |-> !o_crc_err)
    else abort_run($sformatf("Fail: o_crc_err got %h expected %h", o_crc_err, 1'b0));

//========================================
// stimulus
//========================================
initial begin
    reg_data_t d;
    reg_addr_t a;
    reg_addr_t bad_addr;
    clk         = 1'b0;
    rst_n       = 1'b0;
    host_req    = 1'b0;
    host_op     = LV_OP_RD;
    host_addr   = '0;
    host_wdata  = '0;
    host_wcrc   = '0;
    scan_en     = 1'b0;
    exp_err     = 1'b0;
    err_allowed = 1'b0;
    for (int i = 0; i < `LV_REG_NUM; i++) begin
        exp_data[i] = '0;
        exp_crc[i]  = '0;
    end
    void'($urandom(77));
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // reset values, scanner parked
    for (int i = 0; i < `LV_REG_NUM; i++) begin
        host_access(LV_OP_RD, reg_addr_t'(i), '0, '0);
    end

    // random traffic against the scanner
    scan_en = 1'b1;
    for (int n = 0; n < 40; n++) begin
        a = reg_addr_t'($urandom % (`LV_REG_NUM - 1));
        if ($urandom % 2) begin
            d = reg_data_t'($urandom);
            host_access(LV_OP_WR, a, d, crc4_remainder(d));
        end else begin
            host_access(LV_OP_RD, a, '0, '0);
        end
    end
    for (int i = 0; i < `LV_REG_NUM - 1; i++) begin
        host_access(LV_OP_RD, reg_addr_t'(i), '0, '0);
    end
    wait_scan_reads(50);

    // corrupt one CRC
    bad_addr    = reg_addr_t'($urandom % (`LV_REG_NUM - 1));
    d           = reg_data_t'($urandom);
    err_allowed = 1'b1;
    host_access(LV_OP_WR, bad_addr, d, crc4_remainder(d) ^ 4'h5);
    wait_crc_err();
    exp_err = 1'b1;
    host_access(LV_OP_RD, STAT_ADDR, '0, '0);
    host_access(LV_OP_RD, bad_addr, '0, '0);

    // repair, then clear the sticky bit
    d = reg_data_t'($urandom);
    host_access(LV_OP_WR, bad_addr, d, crc4_remainder(d));
    host_access(LV_OP_WR, STAT_ADDR, 8'h01, crc4_remainder(8'h01));
    exp_err     = 1'b0;
    err_allowed = 1'b0;
    wait_scan_reads(`LV_REG_NUM);   // one full round and then some
    host_access(LV_OP_RD, STAT_ADDR, '0, '0);
    for (int i = 0; i < `LV_REG_NUM - 1; i++) begin
        host_access(LV_OP_RD, reg_addr_t'(i), '0, '0);
    end

    $display("SIMULATION PASSED");
    $finish;
end

endmodule

`default_nettype wire

// File: lv_core.f
+incdir+hdl
hdl/lv_pkg.sv
hdl/lv_wdg_scan.sv
hdl/lv_reg_access_ctrl.sv
hdl/lv_reg_slv.sv
hdl/lv_core.sv
sim/tb_lv_core.sv

// File: run_sim.sh
#!/bin/sh
# build the lv_core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lv_core -f lv_core.f \
    && ./obj_dir/Vtb_lv_core 2>&1 | tee /dev/stderr | grep -q "SIMULATION PASSED" \
    && echo "run_sim: lv_core simulation ok" \
    || { echo "run_sim: lv_core simulation failed"; exit 1; }
